/* bench/tb_gpio.sv */
/*
 * Self-checking testbench for the GPIO peripheral. A register model and a
 * reference function predict each bus response; a compare process checks
 * responses in order, and a watchdog bounds the run time.
 */
`default_nettype none

module tb_gpio;

    timeunit 1ns;
    timeprecision 1ps;

    import bus_pkg::*;
    import gpio_pkg::*;

    localparam int unsigned SYNC_STAGES = 2;
    localparam int unsigned SEED        = 19;
    localparam int unsigned N_RANDOM    = 200;
    // Worst case with a gap after every random request
    localparam int unsigned TXN_COUNT   = 2 * N_RANDOM + 60;
    localparam int unsigned SETTLE_CYC  = 8 * (SYNC_STAGES + 2) + 10;
    localparam int unsigned TIMEOUT_NS  = (TXN_COUNT + SETTLE_CYC) * 40 * 2;

    // Expected response and the cycle it must show up in
    typedef struct packed {
        int unsigned due;
        bus_rsp_t    rsp;
    } exp_t;

    logic       clk = 1'b0;
    logic       rst_n;
    bus_req_t   req;
    bus_rsp_t   rsp;
    gpio_word_t gpio_o;
    gpio_word_t gpio_e;
    gpio_word_t gpio_i;
    logic       irq;

    // Register model
    gpio_word_t out_m;
    gpio_word_t oe_m;
    gpio_word_t in_m;
    gpio_word_t flags_m;

    exp_t        exp_q [$];
    int unsigned cycle_cnt = 0;

    gpio_subsys #(
        .SYNC_STAGES (SYNC_STAGES)
    ) dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .rsp    (rsp),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i),
        .irq    (irq)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    // Expected response from the register map rules
    function automatic bus_rsp_t ref_rsp(input bus_req_t r, input gpio_word_t out_v,
                                         input gpio_word_t oe_v, input gpio_word_t in_v,
                                         input gpio_word_t flags_v);
        bus_rsp_t e;
        e     = '0;
        e.vld = 1'b1;
        if (r.adr >= 8'h10) begin
            e.err = 1'b1;
        end else if (!r.wen) begin
            // Word select from bits 3:2 with the low bits ignored
            case (r.adr[3:2])
                2'd0: e.rdt[GPIO_W-1:0] = out_v;
                2'd1: e.rdt[GPIO_W-1:0] = oe_v;
                2'd2: e.rdt[GPIO_W-1:0] = in_v;
                default: e.rdt[GPIO_W-1:0] = flags_v;
            endcase
        end
        return e;
    endfunction

    // State change caused by one accepted request
    task automatic update_model(input bus_req_t r);
        if (r.wen && r.adr < 8'h10) begin
            case (r.adr[3:2])
                2'd0: out_m = r.wdt[GPIO_W-1:0];
                2'd1: oe_m = r.wdt[GPIO_W-1:0];
                2'd3: flags_m = flags_m & ~r.wdt[GPIO_W-1:0];
                default: ;  // Input register is read only
            endcase
        end
    endtask

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_pins(input string name, input gpio_word_t exp, input gpio_word_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_irq(input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED irq: expected 0x%h, got 0x%h", exp, act);
            stop_run();
        end
    endtask

    // Match each response against the oldest expected entry
    always @(negedge clk) begin : compare
        exp_t ent;
        if (rsp.vld && exp_q.size() == 0) begin
            $display("A response arrived with no request outstanding");
            stop_run();
        end else if (rsp.vld && exp_q[0].due != cycle_cnt) begin
            $display("A response arrived in the wrong cycle");
            stop_run();
        end else if (!rsp.vld && exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
            $display("An expected response never appeared");
            stop_run();
        end else if (rsp.vld) begin
            ent = exp_q.pop_front();
            check_rsp("rsp", ent.rsp, rsp);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers entered on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    function automatic bus_req_t make_req(input logic wen, input logic [BUS_AW-1:0] adr,
                                          input logic [BUS_DW-1:0] wdt);
        bus_req_t r;
        r.vld = 1'b1;
        r.wen = wen;
        r.adr = adr;
        r.wdt = wdt;
        return r;
    endfunction

    // Drive one request for one cycle and queue its expected response
    task automatic issue(input bus_req_t r);
        exp_t ent;
        req = r;
        ent.due = cycle_cnt + 1;
        ent.rsp = ref_rsp(r, out_m, oe_m, in_m, flags_m);
        exp_q.push_back(ent);
        update_model(r);
        @(negedge clk);
        req = '0;
    endtask

    task automatic write_reg(input logic [BUS_AW-1:0] adr, input logic [BUS_DW-1:0] data);
        issue(make_req(1'b1, adr, data));
    endtask

    task automatic read_reg(input logic [BUS_AW-1:0] adr);
        issue(make_req(1'b0, adr, '0));
    endtask

    task automatic idle(input int unsigned n);
        req = '0;
        repeat (n) @(negedge clk);
    endtask

    // New pin value held until the edge flags have settled
    task automatic set_inputs(input gpio_word_t v);
        gpio_i = v;
        idle(SYNC_STAGES + 2);
        flags_m = flags_m | (v & ~in_m);
        in_m    = v;
    endtask

    task automatic check_outputs();
        check_pins("gpio_o", out_m, gpio_o);
        check_pins("gpio_e", oe_m, gpio_e);
        check_pins("edge_flags", flags_m, dut.edge_flags);
        check_irq(flags_m != '0, irq);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns", TIMEOUT_NS);
        stop_run();
    end

    initial begin : main
        logic [BUS_AW-1:0] adr;
        int unsigned       sel;
        void'($urandom(SEED));
        rst_n   = 1'b0;
        req     = '0;
        gpio_i  = '0;
        out_m   = '0;
        oe_m    = '0;
        in_m    = '0;
        flags_m = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        idle(1);

        // Reset values
        check_outputs();
        read_reg(8'h0);
        read_reg(8'h4);
        read_reg(8'h8);
        read_reg(8'hC);

        // Output and enable with the upper data bits dropped
        write_reg(8'h0, $urandom());
        check_outputs();
        write_reg(8'h5, $urandom());  // Byte offset ignored
        check_outputs();
        read_reg(8'h0);
        read_reg(8'h4);
        write_reg(8'h8, $urandom());
        check_outputs();
        read_reg(8'h8);

        // Input path
        set_inputs(gpio_word_t'($urandom()));
        read_reg(8'h8);
        read_reg(8'hC);
        write_reg(8'hC, 32'hFFFF_FFFF);
        check_outputs();

        // Rising bits 0x3030 flagged and falling bits 0x0303 ignored
        set_inputs(16'h0F0F);
        write_reg(8'hC, 32'h0000_FFFF);
        check_outputs();
        set_inputs(16'h3C3C);
        check_outputs();
        read_reg(8'hC);
        write_reg(8'hC, 32'h0000_1010);
        check_outputs();
        write_reg(8'hC, 32'h0000_2020);
        check_outputs();

        // Unmapped region
        set_inputs(16'hFFFF);
        write_reg(8'h10, $urandom());
        write_reg(8'hFC, $urandom());
        read_reg(8'h10);
        read_reg(8'h83);
        check_outputs();

        // Pipelined random traffic with the pins stable
        for (int i = 0; i < N_RANDOM; i++) begin
            sel = $urandom_range(5);
            if (sel == 5) begin
                adr = 8'($urandom_range(255, 16));
            end else begin
                adr = 8'(sel * 4 + $urandom_range(3));
            end
            issue(make_req(1'($urandom_range(1)), adr, $urandom()));
            if ($urandom_range(3) == 0) begin
                idle(1);
            end
        end
        idle(3);
        check_outputs();

        if (exp_q.size() != 0) begin
            $display("Responses still outstanding at the end of the run");
            stop_run();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule : tb_gpio

`default_nettype wire

/* common/bus_pkg.sv */
/*
 * Bus widths and request/response structs for the pipelined register bus.
 * A request transfers whenever vld is high; the response follows one cycle later.
 */
`default_nettype none

package bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    // Byte address width
    localparam int unsigned BUS_AW = 8;
    // Data width
    localparam int unsigned BUS_DW = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Request and response
    ////////////////////////////////////////////////////////////////////////////

    // Manager to subordinate, transfer in every cycle with vld high
    typedef struct packed {
        logic              vld;  // Request present
        logic              wen;  // Write when high, read when low
        logic [BUS_AW-1:0] adr;  // Byte address
        logic [BUS_DW-1:0] wdt;  // Write data
    } bus_req_t;

    // Subordinate to manager, one cycle after the transfer
    typedef struct packed {
        logic              vld;  // Response present, single cycle
        logic              err;  // Unmapped address
        logic [BUS_DW-1:0] rdt;  // Read data
    } bus_rsp_t;

endpackage : bus_pkg

`default_nettype wire

/* common/gpio_pkg.sv */
/*
 * GPIO pin width, register map and pin word type.
 * Shared by the GPIO core blocks and the bus subordinate.
 */
`default_nettype none

package gpio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Pin width
    ////////////////////////////////////////////////////////////////////////////

    // Number of pins, must not exceed the bus data width
    localparam int unsigned GPIO_W = 16;

    // One bit per pin
    typedef logic [GPIO_W-1:0] gpio_word_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    // Word index width and its position in the byte address
    localparam int unsigned REG_IDX_W   = 2;
    localparam int unsigned GPIO_IDX_LSB = 2;

    // Byte size of the mapped region, 0x10 and up is unmapped
    localparam int unsigned GPIO_MAP_SIZE = 16;

    // Word index into the map
    typedef enum logic [REG_IDX_W-1:0] {
        // 0x0 output value
        REG_OUT  = 2'd0,
        // 0x4 output enable
        REG_OE   = 2'd1,
        // 0x8 synchronized input, read only
        REG_IN   = 2'd2,
        // 0xC rising edge flags, write 1 to clear
        REG_EDGE = 2'd3
    } gpio_reg_e;

endpackage : gpio_pkg

`default_nettype wire

/* gpio/gpio_bus_sub.sv */
/*
 * Bus subordinate for the GPIO core. Accepts every request in its cycle,
 * decodes the register index and answers one cycle later with a registered
 * response; addresses outside the map return err with zero data.
 */
`default_nettype none

module gpio_bus_sub (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // Bus side
    input  wire bus_pkg::bus_req_t    req,
    output bus_pkg::bus_rsp_t         rsp,
    // Register side
    output logic                      wr_en,
    output gpio_pkg::gpio_reg_e       reg_idx,
    output gpio_pkg::gpio_word_t      wr_data,
    input  wire gpio_pkg::gpio_word_t rd_data
);

    import bus_pkg::*;
    import gpio_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////////////////////////////////////////

    // Address falls inside the register map
    logic mapped;
    // Mapped read in this cycle
    logic rd_hit;

    assign mapped = (req.adr < GPIO_MAP_SIZE);
    assign rd_hit = req.vld && !req.wen && mapped;

    // Writes reach the registers only for mapped addresses
    assign wr_en = req.vld && req.wen && mapped;

    // Word index from address bits 3:2, byte offset ignored
    assign reg_idx = gpio_reg_e'(req.adr[GPIO_IDX_LSB +: REG_IDX_W]);

    // Upper write data bits have no register behind them
    assign wr_data = req.wdt[GPIO_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Registered response
    ////////////////////////////////////////////////////////////////////////////

    logic              rsp_vld;
    logic              rsp_err;
    logic [BUS_DW-1:0] rsp_rdt;

    // Response valid exactly one cycle after each transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= req.vld;
        end
    end

    // Status and data captured with the transfer
    always_ff @(posedge clk) begin
        if (req.vld) begin
            rsp_err <= !mapped;
            // Zero-extended read word, zero for writes and errors
            rsp_rdt <= rd_hit ? BUS_DW'(rd_data) : '0;
        end
    end

    always_comb begin
        rsp     = '0;
        rsp.vld = rsp_vld;
        rsp.err = rsp_err;
        rsp.rdt = rsp_rdt;
    end

endmodule : gpio_bus_sub

`default_nettype wire

/* gpio/gpio_edge.sv */
/*
 * Rising-edge detector with a write-1-to-clear flag register.
 * Any set flag raises irq; a new edge beats a clear of the same bit.
 */
`default_nettype none

module gpio_edge (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire gpio_pkg::gpio_word_t pin_sync,
    input  wire gpio_pkg::gpio_word_t edge_clr,
    output gpio_pkg::gpio_word_t      edge_flags,
    output logic                      irq
);

    import gpio_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Edge detection
    ////////////////////////////////////////////////////////////////////////////

    // Synchronized input from the previous cycle
    gpio_word_t prev_q;
    // Bits going 0 to 1 this cycle
    gpio_word_t rise;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_q <= '0;
        end else begin
            prev_q <= pin_sync;
        end
    end

    assign rise = pin_sync & ~prev_q;

    ////////////////////////////////////////////////////////////////////////////
    // Flag register
    ////////////////////////////////////////////////////////////////////////////

    gpio_word_t flags_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else begin
            // Clear first, then OR in new edges so a set wins
            flags_q <= (flags_q & ~edge_clr) | rise;
        end
    end

    assign edge_flags = flags_q;

    // Level interrupt, high while any flag is pending
    assign irq = |flags_q;

endmodule : gpio_edge

`default_nettype wire

/* gpio/gpio_regs.sv */
/*
 * GPIO register file: output value and output enable registers,
 * write decode for the map and the combinational read multiplexer.
 * The edge flags live in gpio_edge; writes to REG_EDGE become a clear mask.
 */
`default_nettype none

module gpio_regs (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // Register access from the bus subordinate
    input  wire logic                 wr_en,
    input  wire gpio_pkg::gpio_reg_e  reg_idx,
    input  wire gpio_pkg::gpio_word_t wr_data,
    output gpio_pkg::gpio_word_t      rd_data,
    // Input path and edge flags
    input  wire gpio_pkg::gpio_word_t pin_sync,
    input  wire gpio_pkg::gpio_word_t edge_flags,
    output gpio_pkg::gpio_word_t      edge_clr,
    // Pin outputs
    output gpio_pkg::gpio_word_t      gpio_o,
    output gpio_pkg::gpio_word_t      gpio_e
);

    import gpio_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////////////////////

    logic wr_out;
    logic wr_oe;
    logic wr_edge;

    // One strobe per writable register, REG_IN has none
    assign wr_out  = wr_en && (reg_idx == REG_OUT);
    assign wr_oe   = wr_en && (reg_idx == REG_OE);
    assign wr_edge = wr_en && (reg_idx == REG_EDGE);

    ////////////////////////////////////////////////////////////////////////////
    // Output and enable registers
    ////////////////////////////////////////////////////////////////////////////

    gpio_word_t out_q;
    gpio_word_t oe_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (wr_out) begin
            out_q <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            oe_q <= '0;
        end else if (wr_oe) begin
            oe_q <= wr_data;
        end
    end

    // Pins follow the registers directly
    assign gpio_o = out_q;
    assign gpio_e = oe_q;

    ////////////////////////////////////////////////////////////////////////////
    // Edge clear
    ////////////////////////////////////////////////////////////////////////////

    // Ones in the written word clear the matching flags
    assign edge_clr = wr_edge ? wr_data : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////////////////////////////////////////

    // Current register values, so a read sees the state before a same-cycle write
    always_comb begin
        rd_data = '0;
        case (reg_idx)
            REG_OUT: begin
                rd_data = out_q;
            end
            REG_OE: begin
                rd_data = oe_q;
            end
            REG_IN: begin
                rd_data = pin_sync;
            end
            REG_EDGE: begin
                rd_data = edge_flags;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule : gpio_regs

`default_nettype wire

/* gpio/gpio_sync.sv */
/*
 * Multi-stage synchronizer for the asynchronous pin inputs.
 * STAGES flip-flop rows per bit; STAGES of 0 passes the input straight through.
 */
`default_nettype none

module gpio_sync #(
    parameter int unsigned STAGES = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire gpio_pkg::gpio_word_t pin_async,
    output gpio_pkg::gpio_word_t      pin_sync
);

    import gpio_pkg::*;

    generate
        if (STAGES == 0) begin : g_bypass
            // No synchronization, input already in the clock domain
            assign pin_sync = pin_async;
        end else begin : g_chain
            // Row 0 samples the pins, last row drives the output
            gpio_word_t sync_q [STAGES];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < STAGES; i++) begin
                        sync_q[i] <= '0;
                    end
                end else begin
                    sync_q[0] <= pin_async;
                    // Shift toward the output
                    for (int i = 1; i < STAGES; i++) begin
                        sync_q[i] <= sync_q[i-1];
                    end
                end
            end

            assign pin_sync = sync_q[STAGES-1];
        end
    endgenerate

endmodule : gpio_sync

`default_nettype wire

/* logic/gpio_subsys.sv */
/*
 * GPIO peripheral top: bus subordinate, register file, input synchronizer
 * and edge detector. SYNC_STAGES sets the input synchronizer depth.
 */
`default_nettype none

module gpio_subsys #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // Register bus
    input  wire bus_pkg::bus_req_t    req,
    output bus_pkg::bus_rsp_t         rsp,
    // Pins
    output gpio_pkg::gpio_word_t      gpio_o,
    output gpio_pkg::gpio_word_t      gpio_e,
    input  wire gpio_pkg::gpio_word_t gpio_i,
    // Interrupt
    output logic                      irq
);

    import gpio_pkg::*;

    // Bus subordinate to register file
    logic       wr_en;
    gpio_reg_e  reg_idx;
    gpio_word_t wr_data;
    gpio_word_t rd_data;

    // Input path and edge flags
    gpio_word_t pin_sync;
    gpio_word_t edge_clr;
    gpio_word_t edge_flags;

    gpio_bus_sub u_bus_sub (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .rsp     (rsp),
        .wr_en   (wr_en),
        .reg_idx (reg_idx),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    gpio_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .reg_idx    (reg_idx),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .pin_sync   (pin_sync),
        .edge_flags (edge_flags),
        .edge_clr   (edge_clr),
        .gpio_o     (gpio_o),
        .gpio_e     (gpio_e)
    );

    // Pins into the clock domain
    gpio_sync #(
        .STAGES (SYNC_STAGES)
    ) u_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .pin_async (gpio_i),
        .pin_sync  (pin_sync)
    );

    gpio_edge u_edge (
        .clk        (clk),
        .rst_n      (rst_n),
        .pin_sync   (pin_sync),
        .edge_clr   (edge_clr),
        .edge_flags (edge_flags),
        .irq        (irq)
    );

endmodule : gpio_subsys

`default_nettype wire

/* project.f */
common/bus_pkg.sv
common/gpio_pkg.sv
gpio/gpio_sync.sv
gpio/gpio_edge.sv
gpio/gpio_regs.sv
gpio/gpio_bus_sub.sv
logic/gpio_subsys.sv
bench/tb_gpio.sv
